//--- hw/video_pkg.sv
/*
 Shared widths, CPU region codes and enums for the scan-out video controller.
 Modules reach these through scoped names such as video_pkg::POS_W.
*/

`default_nettype none

package video_pkg;

	// ==========================================================
	// Bus and pixel widths
	// ==========================================================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int PIXEL_W = 24;
	localparam int POS_W = 11;

	// Region codes in CPU address bits 23:20.
	localparam logic [3:0] REGION_PALETTE = 4'he;
	localparam logic [3:0] REGION_CONTROL = 4'hf;

	// Control bank registers, selected by CPU address bits 4:2.
	typedef enum logic [2:0] {
		REG_READ_OFFSET = 3'd0,
		REG_PITCH = 3'd1,
		REG_DOUBLE = 3'd2,
		REG_SKIP_X = 3'd3,
		REG_SKIP_Y = 3'd4,
		REG_USE_PALETTE = 3'd5
	} reg_index_t;

	// CPU access FSM.
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PALETTE,
		ST_MEMORY,
		ST_CONTROL,
		ST_HOLD
	} cpu_state_t;

endpackage

`default_nettype wire

//--- hw/video_timing.sv
/*
 Raster timing generator. Produces the pixel position, blanking flags and a
 one-cycle line-start strobe at the first hblank cycle ahead of each active line.
*/

`timescale 1ns/1ps
`default_nettype none

module video_timing #(
	parameter int ACTIVE_W = 32,
	parameter int ACTIVE_H = 8,
	parameter int HBLANK_LEN = 24,
	parameter int VBLANK_LEN = 2
)(
	input wire i_clock,
	input wire i_rst_n,
	output logic [video_pkg::POS_W-1:0] o_pos_x,
	output logic [video_pkg::POS_W-1:0] o_pos_y,
	output logic o_hblank,
	output logic o_vblank,
	output logic o_line_start
);

	localparam int PW = video_pkg::POS_W;
	localparam int LINE_LEN = ACTIVE_W + HBLANK_LEN;
	localparam int FRAME_LEN = ACTIVE_H + VBLANK_LEN;

	// Position counters.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_pos_x <= '0;
			o_pos_y <= '0;
		end else if (o_pos_x == PW'(LINE_LEN - 1)) begin
			o_pos_x <= '0;
			if (o_pos_y == PW'(FRAME_LEN - 1)) begin
				o_pos_y <= '0;
			end else begin
				o_pos_y <= o_pos_y + 1'b1;
			end
		end else begin
			o_pos_x <= o_pos_x + 1'b1;
		end
	end

	assign o_hblank = (o_pos_x >= PW'(ACTIVE_W));
	assign o_vblank = (o_pos_y >= PW'(ACTIVE_H));

	// Strobe ahead of every active line, the first one from the last vblank line.
	assign o_line_start = (o_pos_x == PW'(ACTIVE_W)) &&
		((o_pos_y < PW'(ACTIVE_H - 1)) || (o_pos_y == PW'(FRAME_LEN - 1)));

endmodule

`default_nettype wire

//--- hw/video_cpu_port.sv
/*
 CPU side of the video controller. Decodes each bus access into a palette
 write, a control register access or a video-memory access on port A.
*/

`timescale 1ns/1ps
`default_nettype none

module video_cpu_port #(
	parameter int ACTIVE_W = 32
)(
	input wire i_clock,
	input wire i_rst_n,

	input wire i_cpu_request,
	input wire i_cpu_rw,
	input wire [video_pkg::ADDR_W-1:0] i_cpu_address,
	input wire [video_pkg::DATA_W-1:0] i_cpu_wdata,
	output logic [video_pkg::DATA_W-1:0] o_cpu_rdata,
	output logic o_cpu_ready,

	output logic o_mema_request,
	output logic o_mema_rw,
	output logic [video_pkg::ADDR_W-1:0] o_mema_address,
	output logic [video_pkg::DATA_W-1:0] o_mema_wdata,
	input wire [video_pkg::DATA_W-1:0] i_mema_rdata,
	input wire i_mema_ready,

	output logic o_pal_we,
	output logic [7:0] o_pal_index,
	output logic [video_pkg::PIXEL_W-1:0] o_pal_data,

	output logic [video_pkg::ADDR_W-1:0] o_read_offset,
	output logic [video_pkg::ADDR_W-1:0] o_pitch,
	output logic [1:0] o_double,
	output logic [video_pkg::POS_W-1:0] o_skip_x,
	output logic [video_pkg::POS_W-1:0] o_skip_y,
	output logic o_use_palette
);

	localparam int AW = video_pkg::ADDR_W;
	localparam int DW = video_pkg::DATA_W;
	localparam int PW = video_pkg::POS_W;

	video_pkg::cpu_state_t state;
	video_pkg::reg_index_t reg_sel;
	logic [3:0] region;

	assign region = i_cpu_address[23:20];
	assign reg_sel = video_pkg::reg_index_t'(i_cpu_address[4:2]);

	// ==========================================================
	// Access FSM and control registers
	// ==========================================================
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= video_pkg::ST_IDLE;
			o_cpu_ready <= 1'b0;
			o_mema_request <= 1'b0;
			o_pal_we <= 1'b0;
			o_read_offset <= '0;
			o_pitch <= AW'(4 * ACTIVE_W);
			o_double <= 2'b00;
			o_skip_x <= '0;
			o_skip_y <= '0;
			o_use_palette <= 1'b1;
		end else begin
			case (state)
				video_pkg::ST_IDLE: begin
					o_cpu_ready <= 1'b0;
					if (i_cpu_request) begin
						if (region == video_pkg::REGION_PALETTE) begin
							o_pal_we <= i_cpu_rw;
							state <= video_pkg::ST_PALETTE;
						end else if (region == video_pkg::REGION_CONTROL) begin
							state <= video_pkg::ST_CONTROL;
						end else begin
							o_mema_request <= 1'b1;
							state <= video_pkg::ST_MEMORY;
						end
					end
				end
				video_pkg::ST_PALETTE: begin
					// Single-cycle palette strobe.
					o_pal_we <= 1'b0;
					o_cpu_ready <= 1'b1;
					state <= video_pkg::ST_HOLD;
				end
				video_pkg::ST_CONTROL: begin
					if (i_cpu_rw) begin
						case (reg_sel)
							video_pkg::REG_READ_OFFSET: o_read_offset <= i_cpu_wdata;
							video_pkg::REG_PITCH: o_pitch <= i_cpu_wdata;
							video_pkg::REG_DOUBLE: o_double <= i_cpu_wdata[1:0];
							video_pkg::REG_SKIP_X: o_skip_x <= i_cpu_wdata[PW-1:0];
							video_pkg::REG_SKIP_Y: o_skip_y <= i_cpu_wdata[PW-1:0];
							video_pkg::REG_USE_PALETTE: o_use_palette <= |i_cpu_wdata;
							default: ;
						endcase
					end
					o_cpu_ready <= 1'b1;
					state <= video_pkg::ST_HOLD;
				end
				video_pkg::ST_MEMORY: begin
					// Stays here while memory stalls.
					if (i_mema_ready) begin
						o_mema_request <= 1'b0;
						o_cpu_ready <= 1'b1;
						state <= video_pkg::ST_HOLD;
					end
				end
				video_pkg::ST_HOLD: begin
					o_cpu_ready <= i_cpu_request;
					if (!i_cpu_request) begin
						state <= video_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= video_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Access fields and read data.
	always_ff @(posedge i_clock) begin
		if (state == video_pkg::ST_IDLE && i_cpu_request) begin
			o_pal_index <= i_cpu_address[9:2];
			o_pal_data <= i_cpu_wdata[video_pkg::PIXEL_W-1:0];
			o_mema_rw <= i_cpu_rw;
			o_mema_address <= {8'h00, i_cpu_address[23:0]};
			o_mema_wdata <= i_cpu_wdata;
		end
		if (state == video_pkg::ST_PALETTE) begin
			o_cpu_rdata <= '0;
		end
		if (state == video_pkg::ST_MEMORY && i_mema_ready) begin
			o_cpu_rdata <= i_mema_rdata;
		end
		if (state == video_pkg::ST_CONTROL) begin
			case (reg_sel)
				video_pkg::REG_READ_OFFSET: o_cpu_rdata <= o_read_offset;
				video_pkg::REG_PITCH: o_cpu_rdata <= o_pitch;
				video_pkg::REG_DOUBLE: o_cpu_rdata <= DW'(o_double);
				video_pkg::REG_SKIP_X: o_cpu_rdata <= DW'(o_skip_x);
				video_pkg::REG_SKIP_Y: o_cpu_rdata <= DW'(o_skip_y);
				video_pkg::REG_USE_PALETTE: o_cpu_rdata <= DW'(o_use_palette);
				default: o_cpu_rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/video_line_fetch.sv
/*
 Line fetcher. On each line-start strobe it reads the source row of the coming
 line from video memory over port B into the line buffer RAM.
*/

`timescale 1ns/1ps
`default_nettype none

module video_line_fetch #(
	parameter int ACTIVE_H = 8,
	parameter int MAX_PITCH = 128,
	localparam int LB_AW = $clog2(MAX_PITCH / 4)
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire i_line_start,
	input wire [video_pkg::POS_W-1:0] i_pos_y,
	input wire [video_pkg::ADDR_W-1:0] i_read_offset,
	input wire [video_pkg::ADDR_W-1:0] i_pitch,
	input wire [1:0] i_double,
	input wire [video_pkg::POS_W-1:0] i_skip_y,

	output logic o_memb_request,
	output logic [video_pkg::ADDR_W-1:0] o_memb_address,
	input wire [video_pkg::DATA_W-1:0] i_memb_rdata,
	input wire i_memb_ready,

	input wire [LB_AW-1:0] i_lb_raddr,
	output logic [video_pkg::DATA_W-1:0] o_lb_rdata,
	output logic o_fetch_busy
);

	localparam int PW = video_pkg::POS_W;
	localparam int PW1 = PW + 1;
	localparam int AW = video_pkg::ADDR_W;
	localparam int LB_DEPTH = MAX_PITCH / 4;
	localparam int CW = LB_AW + 1;

	logic [video_pkg::DATA_W-1:0] lb_mem [0:LB_DEPTH-1];

	logic [PW-1:0] next_line;
	logic [PW-1:0] row_off;
	logic [PW-1:0] src_row;
	logic in_window;
	logic [AW-1:0] word_total;
	logic [CW-1:0] word_limit;
	logic [CW-1:0] word_cnt;
	logic [CW-1:0] word_last;
	logic fetch_done;
	logic accept;

	// ==========================================================
	// Source row of the coming line
	// ==========================================================
	always_comb begin
		next_line = (i_pos_y >= PW'(ACTIVE_H)) ? '0 : i_pos_y + 1'b1;
		in_window = (next_line >= i_skip_y) &&
			(({1'b0, next_line} + {1'b0, i_skip_y}) < PW1'(ACTIVE_H));
		row_off = next_line - i_skip_y;
		src_row = i_double[1] ? (row_off >> 1) : row_off;
		word_total = {2'b00, i_pitch[AW-1:2]};
		// Never more words than the buffer holds.
		word_limit = (word_total > AW'(LB_DEPTH)) ? CW'(LB_DEPTH) : CW'(word_total);
	end

	assign accept = o_memb_request && i_memb_ready;

	// Fetch control.
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_memb_request <= 1'b0;
			fetch_done <= 1'b1;
		end else if (i_line_start) begin
			if (in_window && word_limit != '0) begin
				o_memb_request <= 1'b1;
				fetch_done <= 1'b0;
			end
		end else if (accept && word_cnt == word_last) begin
			o_memb_request <= 1'b0;
			fetch_done <= 1'b1;
		end
	end

	// Address and word count.
	always_ff @(posedge i_clock) begin
		if (i_line_start) begin
			o_memb_address <= i_read_offset + AW'(src_row) * i_pitch;
			word_cnt <= '0;
			word_last <= word_limit - 1'b1;
		end else if (accept) begin
			o_memb_address <= o_memb_address + AW'(4);
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// Line buffer, one write and one registered read port.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			lb_mem[word_cnt[LB_AW-1:0]] <= i_memb_rdata;
		end
		o_lb_rdata <= lb_mem[i_lb_raddr];
	end

	assign o_fetch_busy = ~fetch_done;

endmodule

`default_nettype wire

//--- hw/video_pixel_out.sv
/*
 Pixel stage. Reads the line buffer, looks up the palette or passes the word
 through, blanks the border and registers pixel, position and blank together.
*/

`timescale 1ns/1ps
`default_nettype none

module video_pixel_out #(
	parameter int ACTIVE_W = 32,
	parameter int ACTIVE_H = 8,
	parameter int MAX_PITCH = 128,
	localparam int LB_AW = $clog2(MAX_PITCH / 4)
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire [video_pkg::POS_W-1:0] i_pos_x,
	input wire [video_pkg::POS_W-1:0] i_pos_y,
	input wire i_hblank,
	input wire i_vblank,

	input wire i_pal_we,
	input wire [7:0] i_pal_index,
	input wire [video_pkg::PIXEL_W-1:0] i_pal_data,

	output logic [LB_AW-1:0] o_lb_raddr,
	input wire [video_pkg::DATA_W-1:0] i_lb_rdata,

	input wire [1:0] i_double,
	input wire [video_pkg::POS_W-1:0] i_skip_x,
	input wire [video_pkg::POS_W-1:0] i_skip_y,
	input wire i_use_palette,

	output logic [video_pkg::PIXEL_W-1:0] o_video_pixel,
	output logic [video_pkg::POS_W-1:0] o_video_x,
	output logic [video_pkg::POS_W-1:0] o_video_y,
	output logic o_video_hblank,
	output logic o_video_vblank,
	output logic o_video_active
);

	localparam int PW = video_pkg::POS_W;
	localparam int PW1 = PW + 1;

	logic [video_pkg::PIXEL_W-1:0] pal_mem [0:255];

	logic [PW:0] col_off;
	logic [PW:0] col;
	logic [PW:0] word_sel;
	logic in_window;
	logic [7:0] pal_sel;
	logic [video_pkg::PIXEL_W-1:0] pixel_next;

	logic s1_valid;
	logic s1_use_palette;
	logic [1:0] s1_lane;
	logic [PW-1:0] s1_x;
	logic [PW-1:0] s1_y;
	logic s1_hblank;
	logic s1_vblank;
	logic s1_active;

	always_ff @(posedge i_clock) begin
		if (i_pal_we) begin
			pal_mem[i_pal_index] <= i_pal_data;
		end
	end

	// ==========================================================
	// Stage 0, column and line buffer address
	// ==========================================================
	always_comb begin
		col_off = {1'b0, i_pos_x} - {1'b0, i_skip_x};
		col = i_double[0] ? (col_off >> 1) : col_off;
		// Four palette indices per word.
		word_sel = i_use_palette ? (col >> 2) : col;
		in_window = !i_hblank && !i_vblank &&
			(i_pos_x >= i_skip_x) && (i_pos_y >= i_skip_y) &&
			(({1'b0, i_pos_x} + {1'b0, i_skip_x}) < PW1'(ACTIVE_W)) &&
			(({1'b0, i_pos_y} + {1'b0, i_skip_y}) < PW1'(ACTIVE_H));
	end

	assign o_lb_raddr = word_sel[LB_AW-1:0];

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			s1_valid <= 1'b0;
			s1_hblank <= 1'b0;
			s1_vblank <= 1'b0;
			s1_active <= 1'b0;
		end else begin
			s1_valid <= in_window;
			s1_hblank <= i_hblank;
			s1_vblank <= i_vblank;
			s1_active <= !i_hblank && !i_vblank;
		end
	end

	always_ff @(posedge i_clock) begin
		s1_lane <= col[1:0];
		s1_use_palette <= i_use_palette;
		s1_x <= i_pos_x;
		s1_y <= i_pos_y;
	end

	// ==========================================================
	// Stage 1, byte lane, palette and output register
	// ==========================================================
	always_comb begin
		case (s1_lane)
			2'd0: pal_sel = i_lb_rdata[7:0];
			2'd1: pal_sel = i_lb_rdata[15:8];
			2'd2: pal_sel = i_lb_rdata[23:16];
			default: pal_sel = i_lb_rdata[31:24];
		endcase
		if (!s1_valid) begin
			pixel_next = '0;
		end else if (s1_use_palette) begin
			pixel_next = pal_mem[pal_sel];
		end else begin
			pixel_next = i_lb_rdata[video_pkg::PIXEL_W-1:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_video_pixel <= '0;
			o_video_hblank <= 1'b0;
			o_video_vblank <= 1'b0;
			o_video_active <= 1'b0;
		end else begin
			o_video_pixel <= pixel_next;
			o_video_hblank <= s1_hblank;
			o_video_vblank <= s1_vblank;
			o_video_active <= s1_active;
		end
	end

	always_ff @(posedge i_clock) begin
		o_video_x <= s1_x;
		o_video_y <= s1_y;
	end

endmodule

`default_nettype wire

//--- hw/video_subsystem.sv
/*
 Top level of the video controller. Sets the raster parameters and connects
 timing, CPU port, line fetcher and pixel stage.
*/

`timescale 1ns/1ps
`default_nettype none

module video_subsystem #(
	parameter int ACTIVE_W = 32,
	parameter int ACTIVE_H = 8,
	parameter int HBLANK_LEN = 24,
	parameter int VBLANK_LEN = 2,
	parameter int MAX_PITCH = 128
)(
	input wire i_clock,
	input wire i_rst_n,

	input wire i_cpu_request,
	input wire i_cpu_rw,
	input wire [video_pkg::ADDR_W-1:0] i_cpu_address,
	input wire [video_pkg::DATA_W-1:0] i_cpu_wdata,
	output wire [video_pkg::DATA_W-1:0] o_cpu_rdata,
	output wire o_cpu_ready,

	output wire o_mema_request,
	output wire o_mema_rw,
	output wire [video_pkg::ADDR_W-1:0] o_mema_address,
	output wire [video_pkg::DATA_W-1:0] o_mema_wdata,
	input wire [video_pkg::DATA_W-1:0] i_mema_rdata,
	input wire i_mema_ready,

	output wire o_memb_request,
	output wire [video_pkg::ADDR_W-1:0] o_memb_address,
	input wire [video_pkg::DATA_W-1:0] i_memb_rdata,
	input wire i_memb_ready,

	output wire [video_pkg::PIXEL_W-1:0] o_video_pixel,
	output wire [video_pkg::POS_W-1:0] o_video_x,
	output wire [video_pkg::POS_W-1:0] o_video_y,
	output wire o_video_hblank,
	output wire o_video_vblank,
	output wire o_video_active
);

	localparam int LB_AW = $clog2(MAX_PITCH / 4);

	wire [video_pkg::POS_W-1:0] pos_x;
	wire [video_pkg::POS_W-1:0] pos_y;
	wire hblank;
	wire vblank;
	wire line_start;

	wire pal_we;
	wire [7:0] pal_index;
	wire [video_pkg::PIXEL_W-1:0] pal_data;

	wire [video_pkg::ADDR_W-1:0] read_offset;
	wire [video_pkg::ADDR_W-1:0] pitch;
	wire [1:0] double_mode;
	wire [video_pkg::POS_W-1:0] skip_x;
	wire [video_pkg::POS_W-1:0] skip_y;
	wire use_palette;

	wire [LB_AW-1:0] lb_raddr;
	wire [video_pkg::DATA_W-1:0] lb_rdata;
	wire fetch_busy;

	video_timing #(
		.ACTIVE_W(ACTIVE_W),
		.ACTIVE_H(ACTIVE_H),
		.HBLANK_LEN(HBLANK_LEN),
		.VBLANK_LEN(VBLANK_LEN)
	) u_timing (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.o_pos_x(pos_x),
		.o_pos_y(pos_y),
		.o_hblank(hblank),
		.o_vblank(vblank),
		.o_line_start(line_start)
	);

	video_cpu_port #(
		.ACTIVE_W(ACTIVE_W)
	) u_cpu_port (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_rw(i_cpu_rw),
		.i_cpu_address(i_cpu_address),
		.i_cpu_wdata(i_cpu_wdata),
		.o_cpu_rdata(o_cpu_rdata),
		.o_cpu_ready(o_cpu_ready),
		.o_mema_request(o_mema_request),
		.o_mema_rw(o_mema_rw),
		.o_mema_address(o_mema_address),
		.o_mema_wdata(o_mema_wdata),
		.i_mema_rdata(i_mema_rdata),
		.i_mema_ready(i_mema_ready),
		.o_pal_we(pal_we),
		.o_pal_index(pal_index),
		.o_pal_data(pal_data),
		.o_read_offset(read_offset),
		.o_pitch(pitch),
		.o_double(double_mode),
		.o_skip_x(skip_x),
		.o_skip_y(skip_y),
		.o_use_palette(use_palette)
	);

	video_line_fetch #(
		.ACTIVE_H(ACTIVE_H),
		.MAX_PITCH(MAX_PITCH)
	) u_line_fetch (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_line_start(line_start),
		.i_pos_y(pos_y),
		.i_read_offset(read_offset),
		.i_pitch(pitch),
		.i_double(double_mode),
		.i_skip_y(skip_y),
		.o_memb_request(o_memb_request),
		.o_memb_address(o_memb_address),
		.i_memb_rdata(i_memb_rdata),
		.i_memb_ready(i_memb_ready),
		.i_lb_raddr(lb_raddr),
		.o_lb_rdata(lb_rdata),
		.o_fetch_busy(fetch_busy)
	);

	video_pixel_out #(
		.ACTIVE_W(ACTIVE_W),
		.ACTIVE_H(ACTIVE_H),
		.MAX_PITCH(MAX_PITCH)
	) u_pixel_out (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_pos_x(pos_x),
		.i_pos_y(pos_y),
		.i_hblank(hblank),
		.i_vblank(vblank),
		.i_pal_we(pal_we),
		.i_pal_index(pal_index),
		.i_pal_data(pal_data),
		.o_lb_raddr(lb_raddr),
		.i_lb_rdata(lb_rdata),
		.i_double(double_mode),
		.i_skip_x(skip_x),
		.i_skip_y(skip_y),
		.i_use_palette(use_palette),
		.o_video_pixel(o_video_pixel),
		.o_video_x(o_video_x),
		.o_video_y(o_video_y),
		.o_video_hblank(o_video_hblank),
		.o_video_vblank(o_video_vblank),
		.o_video_active(o_video_active)
	);

endmodule

`default_nettype wire

//--- verification/video_assertions.sv
/*
 Protocol assertions, bound into the video controller top level.
 Covers the CPU handshake, port A stability, fetch timing and blank pixels.
*/

`timescale 1ns/1ps
`default_nettype none

module video_assertions (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_cpu_request,
	input wire i_cpu_ready,
	input wire i_mema_request,
	input wire i_mema_rw,
	input wire [31:0] i_mema_address,
	input wire [31:0] i_mema_wdata,
	input wire i_mema_ready,
	input wire i_hblank,
	input wire i_vblank,
	input wire i_fetch_busy,
	input wire i_video_active,
	input wire [23:0] i_video_pixel
);

	int fail_count = 0;

	// Ready only answers a request pending in the cycle before.
	ready_needs_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$rose(i_cpu_ready) |-> $past(i_cpu_request))
		else begin
			$error("CPU ready rose without a request");
			fail_count++;
		end

	// Port A fields hold while the request waits.
	mema_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_mema_request && !i_mema_ready) |=>
		($stable(i_mema_address) && $stable(i_mema_rw) && $stable(i_mema_wdata)))
		else begin
			$error("Port A fields changed while pending");
			fail_count++;
		end

	// Row fetch must be over before active pixels.
	fetch_in_hblank: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(!i_hblank && !i_vblank) |-> !i_fetch_busy)
		else begin
			$error("Line fetch still busy in active video");
			fail_count++;
		end

	blank_is_black: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		!i_video_active |-> (i_video_pixel == 24'h0))
		else begin
			$error("Nonzero pixel outside active video");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- verification/video_tb.sv
/*
 Testbench for the video controller. Drives the CPU bus, models both
 video-memory ports and checks the scanned-out pixels against a reference model.
*/

`timescale 1ns/1ps
`default_nettype none

module video_tb;

	localparam int ACTIVE_W = 32;
	localparam int ACTIVE_H = 8;
	localparam int HBLANK_LEN = 64;
	localparam int VBLANK_LEN = 2;
	localparam int MAX_PITCH = 128;
	localparam int LINE_LEN = ACTIVE_W + HBLANK_LEN;
	localparam int FRAME_LINES = ACTIVE_H + VBLANK_LEN;
	localparam int FRAME_LEN = LINE_LEN * FRAME_LINES;
	// Palette load plus register tests, then about two frames per video scenario.
	localparam int SETUP_CYCLES = 256 * 8 + 400;
	localparam int CYCLE_LIMIT = SETUP_CYCLES + 10 * FRAME_LEN;
	localparam int VIDEO_SCENARIOS = 4;

	logic clock;
	logic rst_n;
	logic cpu_request;
	logic cpu_rw;
	logic [31:0] cpu_address;
	logic [31:0] cpu_wdata;
	wire [31:0] cpu_rdata;
	wire cpu_ready;
	wire mema_request;
	wire mema_rw;
	wire [31:0] mema_address;
	wire [31:0] mema_wdata;
	logic [31:0] mema_rdata;
	logic mema_ready;
	wire memb_request;
	wire [31:0] memb_address;
	wire [31:0] memb_rdata;
	logic memb_ready;
	wire [23:0] video_pixel;
	wire [10:0] video_x;
	wire [10:0] video_y;
	wire video_hblank;
	wire video_vblank;
	wire video_active;

	logic [31:0] mema_array [0:255];
	logic [23:0] pal_shadow [0:255];
	logic [31:0] cfg_offset;
	logic [31:0] cfg_pitch;
	logic [1:0] cfg_double;
	int cfg_skip_x;
	int cfg_skip_y;
	logic cfg_palette;
	logic check_en;
	int errors;
	int pixels_checked;
	int cycle_count;
	int raster_count;
	logic [31:0] read_word;
	logic [31:0] write_word;
	int latency;

	video_subsystem #(
		.ACTIVE_W(ACTIVE_W),
		.ACTIVE_H(ACTIVE_H),
		.HBLANK_LEN(HBLANK_LEN),
		.VBLANK_LEN(VBLANK_LEN),
		.MAX_PITCH(MAX_PITCH)
	) UUT (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.i_cpu_request(cpu_request),
		.i_cpu_rw(cpu_rw),
		.i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata),
		.o_cpu_rdata(cpu_rdata),
		.o_cpu_ready(cpu_ready),
		.o_mema_request(mema_request),
		.o_mema_rw(mema_rw),
		.o_mema_address(mema_address),
		.o_mema_wdata(mema_wdata),
		.i_mema_rdata(mema_rdata),
		.i_mema_ready(mema_ready),
		.o_memb_request(memb_request),
		.o_memb_address(memb_address),
		.i_memb_rdata(memb_rdata),
		.i_memb_ready(memb_ready),
		.o_video_pixel(video_pixel),
		.o_video_x(video_x),
		.o_video_y(video_y),
		.o_video_hblank(video_hblank),
		.o_video_vblank(video_vblank),
		.o_video_active(video_active)
	);

	bind video_subsystem video_assertions u_assert (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_cpu_request(i_cpu_request),
		.i_cpu_ready(o_cpu_ready),
		.i_mema_request(o_mema_request),
		.i_mema_rw(o_mema_rw),
		.i_mema_address(o_mema_address),
		.i_mema_wdata(o_mema_wdata),
		.i_mema_ready(i_mema_ready),
		.i_hblank(hblank),
		.i_vblank(vblank),
		.i_fetch_busy(fetch_busy),
		.i_video_active(o_video_active),
		.i_video_pixel(o_video_pixel)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// ==========================================================
	// Memory models
	// ==========================================================
	// Port B data is the word address with the top byte cleared.
	assign memb_rdata = {8'h00, memb_address[23:0]};

	always @(posedge clock) begin
		if (mema_request && mema_ready && mema_rw) begin
			mema_array[mema_address[9:2]] = mema_wdata;
		end
		#2;
		memb_ready = ($urandom % 4) != 0;
		if (mema_request && !mema_ready) begin
			mema_ready = ($urandom % 3) == 0;
			mema_rdata = mema_array[mema_address[9:2]];
		end else begin
			mema_ready = 1'b0;
		end
	end

	// Expected pixel from the register shadow, palette shadow and memory rule.
	function automatic logic [23:0] model_pixel(input int x, input int y);
		int col;
		int row;
		logic [31:0] addr;
		logic [31:0] data;
		logic [7:0] idx;
		if (x < cfg_skip_x || y < cfg_skip_y || x + cfg_skip_x >= ACTIVE_W ||
			y + cfg_skip_y >= ACTIVE_H) begin
			return 24'h0;
		end
		col = cfg_double[0] ? (x - cfg_skip_x) / 2 : x - cfg_skip_x;
		row = cfg_double[1] ? (y - cfg_skip_y) / 2 : y - cfg_skip_y;
		addr = cfg_offset + row * cfg_pitch + 4 * (cfg_palette ? col / 4 : col);
		data = addr & 32'h00ff_ffff;
		if (!cfg_palette) begin
			return data[23:0];
		end
		idx = 8'(data >> (8 * (col % 4)));
		return pal_shadow[idx];
	endfunction

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// Scoreboard. The outputs trail the raster position by two cycles.
	always @(posedge clock) begin : scoreboard
		int exp_x;
		int exp_y;
		logic exp_active;
		logic [23:0] exp_pixel;
		if (!rst_n) begin
			raster_count = -2;
		end else begin
			if (raster_count >= 0) begin
				exp_x = raster_count % LINE_LEN;
				exp_y = (raster_count / LINE_LEN) % FRAME_LINES;
				exp_active = (exp_x < ACTIVE_W) && (exp_y < ACTIVE_H);
				check_word("o_video_x", 32'(exp_x), 32'(video_x));
				check_word("o_video_y", 32'(exp_y), 32'(video_y));
				check_word("o_video_hblank", 32'(exp_x >= ACTIVE_W), 32'(video_hblank));
				check_word("o_video_vblank", 32'(exp_y >= ACTIVE_H), 32'(video_vblank));
				check_word("o_video_active", 32'(exp_active), 32'(video_active));
				if (check_en && exp_active) begin
					pixels_checked++;
					exp_pixel = model_pixel(exp_x, exp_y);
					if (video_pixel !== exp_pixel) begin
						errors++;
						$display("ERROR t=%0t o_video_pixel (x=%0d y=%0d) expected %h actual %h",
							$time, exp_x, exp_y, exp_pixel, video_pixel);
					end
				end
			end
			raster_count++;
		end
	end

	// ==========================================================
	// CPU bus tasks
	// ==========================================================
	task automatic cpu_access(input logic rw, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output int cycles);
		cycles = 0;
		cpu_request = 1'b1;
		cpu_rw = rw;
		cpu_address = addr;
		cpu_wdata = wdata;
		do begin
			@(posedge clock);
			#1;
			cycles++;
		end while (!cpu_ready && cycles < 200);
		if (!cpu_ready) begin
			errors++;
			$display("CPU access to address %h never received ready", addr);
		end
		rdata = cpu_rdata;
		#1;
		cpu_request = 1'b0;
		do begin
			@(posedge clock);
			#2;
		end while (cpu_ready);
	endtask

	task automatic write_reg(input int index, input logic [31:0] value);
		logic [31:0] unused;
		int cycles;
		cpu_access(1'b1, 32'h00f0_0000 | (index << 2), value, unused, cycles);
	endtask

	// Writes a configuration at the start of vblank and checks the next frame.
	task automatic show_frame(input logic [31:0] offset, input logic [31:0] pitch,
		input logic [1:0] dbl, input int skip_x, input int skip_y, input logic pal);
		wait (video_vblank == 1'b0);
		wait (video_vblank == 1'b1);
		@(posedge clock);
		#2;
		cfg_offset = offset;
		cfg_pitch = pitch;
		cfg_double = dbl;
		cfg_skip_x = skip_x;
		cfg_skip_y = skip_y;
		cfg_palette = pal;
		write_reg(0, offset);
		write_reg(1, pitch);
		write_reg(2, {30'd0, dbl});
		write_reg(3, skip_x);
		write_reg(4, skip_y);
		write_reg(5, {31'd0, pal});
		wait (video_vblank == 1'b0);
		check_en = 1'b1;
		wait (video_vblank == 1'b1);
		check_en = 1'b0;
	endtask

	// Timeout guard.
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles", cycle_count);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(55));
		rst_n = 1'b0;
		cpu_request = 1'b0;
		cpu_rw = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;
		mema_rdata = '0;
		mema_ready = 1'b0;
		memb_ready = 1'b0;
		check_en = 1'b0;
		errors = 0;
		pixels_checked = 0;
		cycle_count = 0;
		repeat (3) @(posedge clock);
		#2;
		rst_n = 1'b1;

		// Control registers read back, ready after 2 cycles.
		for (int i = 0; i < 6; i++) begin
			cpu_access(1'b1, 32'h00f0_0000 | (i << 2), 32'h0 + i + 1, read_word, latency);
			check_word("o_cpu_ready latency", 32'd2, latency);
			cpu_access(1'b0, 32'h00f0_0000 | (i << 2), 32'h0, read_word, latency);
			check_word("o_cpu_rdata", (i == 2) ? 32'd3 : ((i == 5) ? 32'd1 : i + 1), read_word);
		end

		// Video memory through port A.
		for (int i = 0; i < 8; i++) begin
			write_word = $urandom;
			cpu_access(1'b1, 32'h0000_0100 + 4 * i, write_word, read_word, latency);
			cpu_access(1'b0, 32'h0000_0100 + 4 * i, 32'h0, read_word, latency);
			check_word("o_cpu_rdata (memory)", write_word, read_word);
		end

		for (int i = 0; i < 256; i++) begin
			pal_shadow[i] = 24'($urandom);
			cpu_access(1'b1, 32'h00e0_0000 | (i << 2), {8'h00, pal_shadow[i]}, read_word,
				latency);
		end

		show_frame(32'h0, 32'd32, 2'b00, 0, 0, 1'b1);
		show_frame(32'h400, 32'd128, 2'b00, 0, 0, 1'b0);
		show_frame(32'h0, 32'd128, 2'b11, 3, 1, 1'b0);
		show_frame(32'h2000, 32'd64, 2'b00, 0, 0, 1'b1);

		if (pixels_checked != VIDEO_SCENARIOS * ACTIVE_W * ACTIVE_H) begin
			errors++;
			$display("Only %0d active pixels were checked", pixels_checked);
		end
		$display("Errors: %0d scoreboard, %0d assertions; pixels checked %0d",
			errors, UUT.u_assert.fail_count, pixels_checked);
		if (errors == 0 && UUT.u_assert.fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
hw/video_pkg.sv
hw/video_timing.sv
hw/video_cpu_port.sv
hw/video_line_fetch.sv
hw/video_pixel_out.sv
hw/video_subsystem.sv
verification/video_assertions.sv
verification/video_tb.sv

//--- Makefile
# Verilator build and run for the video controller testbench.

LOG = sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f list.f --top-module video_tb -Mdir obj_dir
	./obj_dir/Vvideo_tb +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^All checks passed$$" $(LOG)

lint:
	verilator --lint-only --timing --assert -f list.f --top-module video_tb

clean:
	rm -rf obj_dir $(LOG)
